/* logic/board_cfg.svh */
`ifndef BOARD_CFG_SVH
`define BOARD_CFG_SVH

// serial adapter timing
// the adapter clock is the divider msb, one period is 256 clk_sys cycles
`define JOY_DIV_BITS       8
`define JOY_CNT_BITS       4
// ticks per frame, count runs 0 to 14
`define JOY_FRAME_LEN      15
// tick count of the first sampled bit, twelve bits follow
`define JOY_FIRST_BIT      2

// bit positions inside a joystick word
`define JOY_BIT_RIGHT      3'd0
`define JOY_BIT_LEFT       3'd1
`define JOY_BIT_DOWN       3'd2
`define JOY_BIT_UP         3'd3
`define JOY_BIT_FIRE1      3'd4
`define JOY_BIT_FIRE2      3'd5

// game inputs are inverted at the output when set
`define INPUTS_ACTIVE_LOW  1'b1

`endif

/* logic/board_inputs.sv */
`timescale 1ns/10ps
`default_nettype none

module board_inputs import board_pkg::*; (
    input  wire logic      clk_sys,
    input  wire logic      game_rst,
    // serial joystick adapter
    output logic           joy_clk,
    output logic           joy_load,
    input  wire logic      joy_data,
    // decoded keyboard keys, active high
    input  wire joy_word_t key_joy1,
    input  wire joy_word_t key_joy2,
    input  wire pair_t     key_coin,
    input  wire pair_t     key_start,
    input  wire logic      key_service,
    input  wire logic      key_pause,
    input  wire logic      key_reset,
    input  wire gfx_t      key_gfx,
    input  wire logic      rot_control,
    // to the game
    output joy_word_t      game_joystick1,
    output joy_word_t      game_joystick2,
    output pair_t          game_coin,
    output pair_t          game_start,
    output logic           game_service,
    output logic           game_pause,
    output gfx_t           gfx_en,
    output logic           soft_rst
);

    joy_serial_t joy1_frame;
    joy_serial_t joy2_frame;
    logic        frame_done;     // one cycle per published frame

    joy_word_t   key_joy1_q;
    joy_word_t   key_joy2_q;
    pair_t       key_coin_q;
    pair_t       key_start_q;
    logic        key_service_q;

    joy_serial_scan joy_serial_scan_i (
        .clk_sys    (clk_sys),
        .game_rst   (game_rst),
        .joy_data   (joy_data),
        .joy_clk    (joy_clk),
        .joy_load   (joy_load),
        .joy1_frame (joy1_frame),
        .joy2_frame (joy2_frame),
        .frame_done (frame_done)
    );

    key_edge_ctrl key_edge_ctrl_i (
        .clk_sys       (clk_sys),
        .game_rst      (game_rst),
        .key_joy1      (key_joy1),
        .key_joy2      (key_joy2),
        .key_coin      (key_coin),
        .key_start     (key_start),
        .key_service   (key_service),
        .key_pause     (key_pause),
        .key_reset     (key_reset),
        .key_gfx       (key_gfx),
        .key_joy1_q    (key_joy1_q),
        .key_joy2_q    (key_joy2_q),
        .key_coin_q    (key_coin_q),
        .key_start_q   (key_start_q),
        .key_service_q (key_service_q),
        .game_pause    (game_pause),
        .gfx_en        (gfx_en),
        .soft_rst      (soft_rst)
    );

    // serial and key paths meet here
    input_merge input_merge_i (
        .clk_sys        (clk_sys),
        .game_rst       (game_rst),
        .joy1_frame     (joy1_frame),
        .joy2_frame     (joy2_frame),
        .frame_done     (frame_done),
        .key_joy1_q     (key_joy1_q),
        .key_joy2_q     (key_joy2_q),
        .key_coin_q     (key_coin_q),
        .key_start_q    (key_start_q),
        .key_service_q  (key_service_q),
        .rot_control    (rot_control),
        .game_joystick1 (game_joystick1),
        .game_joystick2 (game_joystick2),
        .game_coin      (game_coin),
        .game_start     (game_start),
        .game_service   (game_service)
    );

endmodule

`default_nettype wire

/* logic/board_pkg.sv */
`default_nettype none

package board_pkg;

    // game joystick word
    // 0 right, 1 left, 2 down, 3 up, 4 fire 1, 5 fire 2, 6..9 extra keys
    typedef logic [9:0] joy_word_t;

    // one player as read from the serial adapter, active high
    typedef logic [5:0] joy_serial_t;

    typedef logic [1:0] pair_t;   // coin and start, bit 0 is player 1

    typedef logic [3:0] gfx_t;    // graphics layer enables

    // scanner phase, follows the tick count
    typedef enum logic [1:0] {
        scan_load,      // count 0, load strobe goes low
        scan_skip,      // load back high, nothing sampled yet
        scan_sample,    // one serial bit per tick
        scan_publish    // shadow copies go out as a frame
    } scan_state_t;

endpackage

`default_nettype wire

/* logic/input_merge.sv */
`timescale 1ns/10ps
`default_nettype none

`include "board_cfg.svh"

module input_merge import board_pkg::*; (
    input  wire logic        clk_sys,
    input  wire logic        game_rst,
    input  wire joy_serial_t joy1_frame,
    input  wire joy_serial_t joy2_frame,
    input  wire logic        frame_done,
    input  wire joy_word_t   key_joy1_q,
    input  wire joy_word_t   key_joy2_q,
    input  wire pair_t       key_coin_q,
    input  wire pair_t       key_start_q,
    input  wire logic        key_service_q,
    input  wire logic        rot_control,
    output joy_word_t        game_joystick1,
    output joy_word_t        game_joystick2,
    output pair_t            game_coin,
    output pair_t            game_start,
    output logic             game_service
);

    localparam int JW = $bits(joy_word_t);
    localparam int SW = $bits(joy_serial_t);
    localparam int PW = $bits(pair_t);

    // inactive level of each output, also the polarity mask
    localparam joy_word_t JOY_IDLE  = {JW{`INPUTS_ACTIVE_LOW}};
    localparam pair_t     PAIR_IDLE = {PW{`INPUTS_ACTIVE_LOW}};

    joy_serial_t joy1_hold;
    joy_serial_t joy2_hold;
    joy_serial_t joy1_src;
    joy_serial_t joy2_src;
    joy_word_t   joy1_mix;
    joy_word_t   joy2_mix;

    // quarter turn for vertical games, buttons untouched
    function automatic joy_word_t apply_rotation(input joy_word_t w, input logic rot);
        joy_word_t r;
        r = w;
        if (rot) begin
            r[`JOY_BIT_RIGHT] = w[`JOY_BIT_DOWN];
            r[`JOY_BIT_LEFT]  = w[`JOY_BIT_UP];
            r[`JOY_BIT_DOWN]  = w[`JOY_BIT_LEFT];
            r[`JOY_BIT_UP]    = w[`JOY_BIT_RIGHT];
        end
        return r;
    endfunction

    // a fresh frame bypasses the hold copy
    assign joy1_src = frame_done ? joy1_frame : joy1_hold;
    assign joy2_src = frame_done ? joy2_frame : joy2_hold;

    // extra buttons 6..9 only come from keys
    assign joy1_mix = {{(JW-SW){1'b0}}, joy1_src} | key_joy1_q;
    assign joy2_mix = {{(JW-SW){1'b0}}, joy2_src} | key_joy2_q;

    always_ff @(posedge clk_sys) begin
        if (game_rst) begin
            joy1_hold <= '0;
            joy2_hold <= '0;
        end else if (frame_done) begin
            joy1_hold <= joy1_frame;
            joy2_hold <= joy2_frame;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (game_rst) begin
            game_joystick1 <= JOY_IDLE;
            game_joystick2 <= JOY_IDLE;
            game_coin      <= PAIR_IDLE;
            game_start     <= PAIR_IDLE;
            game_service   <= `INPUTS_ACTIVE_LOW;
        end else begin
            game_joystick1 <= JOY_IDLE ^ apply_rotation(joy1_mix, rot_control);
            game_joystick2 <= JOY_IDLE ^ apply_rotation(joy2_mix, rot_control);
            game_coin      <= PAIR_IDLE ^ key_coin_q;
            game_start     <= PAIR_IDLE ^ key_start_q;
            game_service   <= `INPUTS_ACTIVE_LOW ^ key_service_q;
        end
    end

endmodule

`default_nettype wire

/* logic/joy_serial_scan.sv */
`timescale 1ns/10ps
`default_nettype none

`include "board_cfg.svh"

module joy_serial_scan import board_pkg::*; (
    input  wire logic   clk_sys,
    input  wire logic   game_rst,
    input  wire logic   joy_data,     // 0 means pressed
    output logic        joy_clk,
    output logic        joy_load,
    output joy_serial_t joy1_frame,
    output joy_serial_t joy2_frame,
    output logic        frame_done
);

    localparam int DIV_MSB  = `JOY_DIV_BITS - 1;
    localparam int CNT_W    = `JOY_CNT_BITS;
    localparam int SER_BITS = $bits(joy_serial_t);

    localparam logic [CNT_W-1:0] LAST_CNT  = CNT_W'(`JOY_FRAME_LEN - 1);
    localparam logic [CNT_W-1:0] FIRST_CNT = CNT_W'(`JOY_FIRST_BIT);
    localparam logic [CNT_W-1:0] P2_SLOT   = CNT_W'(SER_BITS);

    logic [DIV_MSB:0] div_q;
    logic [CNT_W-1:0] cnt_q;
    logic [CNT_W-1:0] cnt_next;
    logic [CNT_W-1:0] slot;
    logic [2:0]       pos;
    logic             player2;
    logic             tick;
    scan_state_t      phase_q;
    joy_serial_t      shd1_q;
    joy_serial_t      shd2_q;

    // phase that belongs to a given tick count
    function automatic scan_state_t phase_of(input logic [CNT_W-1:0] cnt);
        if (cnt == '0) begin
            return scan_load;
        end else if (cnt < FIRST_CNT) begin
            return scan_skip;
        end else if (cnt == LAST_CNT) begin
            return scan_publish;
        end
        return scan_sample;
    endfunction

    // adapter shifts fire 2, fire 1, right, left, down, up
    function automatic logic [2:0] serial_bit(input logic [2:0] p);
        case (p)
            3'd0:    return `JOY_BIT_FIRE2;
            3'd1:    return `JOY_BIT_FIRE1;
            3'd2:    return `JOY_BIT_RIGHT;
            3'd3:    return `JOY_BIT_LEFT;
            3'd4:    return `JOY_BIT_DOWN;
            default: return `JOY_BIT_UP;
        endcase
    endfunction

    // msb rises on the next edge
    assign tick     = (div_q == {1'b0, {DIV_MSB{1'b1}}});
    assign cnt_next = (cnt_q == LAST_CNT) ? '0 : cnt_q + 1'b1;
    assign joy_clk  = div_q[DIV_MSB];

    // which player and which bit the current count samples
    assign slot    = cnt_q - FIRST_CNT;
    assign player2 = (slot >= P2_SLOT);
    assign pos     = 3'(player2 ? slot - P2_SLOT : slot);

    always_ff @(posedge clk_sys) begin
        if (game_rst) begin
            div_q      <= '0;
            cnt_q      <= '0;
            phase_q    <= scan_load;
            joy_load   <= 1'b1;
            joy1_frame <= '0;
            joy2_frame <= '0;
            frame_done <= 1'b0;
        end else begin
            div_q      <= div_q + 1'b1;
            frame_done <= 1'b0;
            if (tick) begin
                cnt_q    <= cnt_next;
                phase_q  <= phase_of(cnt_next);
                joy_load <= (phase_q != scan_load);   // low for one tick
                if (phase_q == scan_publish) begin
                    // both players change in the same cycle
                    joy1_frame <= ~shd1_q;
                    joy2_frame <= ~shd2_q;
                    frame_done <= 1'b1;
                end
            end
        end
    end

    // shadow copies, raw active low samples
    always_ff @(posedge clk_sys) begin
        if (tick && phase_q == scan_sample) begin
            if (player2) begin
                shd2_q[serial_bit(pos)] <= joy_data;
            end else begin
                shd1_q[serial_bit(pos)] <= joy_data;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/key_edge_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module key_edge_ctrl import board_pkg::*; (
    input  wire logic      clk_sys,
    input  wire logic      game_rst,
    input  wire joy_word_t key_joy1,
    input  wire joy_word_t key_joy2,
    input  wire pair_t     key_coin,
    input  wire pair_t     key_start,
    input  wire logic      key_service,
    input  wire logic      key_pause,
    input  wire logic      key_reset,
    input  wire gfx_t      key_gfx,
    output joy_word_t      key_joy1_q,
    output joy_word_t      key_joy2_q,
    output pair_t          key_coin_q,
    output pair_t          key_start_q,
    output logic           key_service_q,
    output logic           game_pause,
    output gfx_t           gfx_en,
    output logic           soft_rst
);

    logic pause_q;
    logic pause_prev;
    logic reset_q;
    logic reset_prev;
    gfx_t gfx_q;
    gfx_t gfx_prev;

    logic pause_rise;
    logic reset_rise;
    gfx_t gfx_rise;

    assign pause_rise = pause_q & ~pause_prev;
    assign reset_rise = reset_q & ~reset_prev;
    assign gfx_rise   = gfx_q & ~gfx_prev;

    // game keys, one sample of the decoder levels
    always_ff @(posedge clk_sys) begin
        key_joy1_q    <= key_joy1;
        key_joy2_q    <= key_joy2;
        key_coin_q    <= key_coin;
        key_start_q   <= key_start;
        key_service_q <= key_service;
    end

    always_ff @(posedge clk_sys) begin
        if (game_rst) begin
            pause_q    <= 1'b0;
            pause_prev <= 1'b0;
            reset_q    <= 1'b0;
            reset_prev <= 1'b0;
            gfx_q      <= '0;
            gfx_prev   <= '0;
            game_pause <= 1'b0;
            gfx_en     <= '1;       // all layers on
            soft_rst   <= 1'b0;
        end else begin
            pause_q    <= key_pause;
            pause_prev <= pause_q;
            reset_q    <= key_reset;
            reset_prev <= reset_q;
            gfx_q      <= key_gfx;
            gfx_prev   <= gfx_q;

            game_pause <= game_pause ^ pause_rise;
            gfx_en     <= gfx_en ^ gfx_rise;   // each key flips only its layer
            soft_rst   <= reset_rise;          // single cycle, even if held
        end
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+logic
logic/board_pkg.sv
logic/joy_serial_scan.sv
logic/key_edge_ctrl.sv
logic/input_merge.sv
logic/board_inputs.sv
tb/board_properties.sv
tb/board_tb.sv

/* tb/board_properties.sv */
`timescale 1ns/10ps
`default_nettype none

module board_properties import board_pkg::*; (
    input wire logic clk_sys,
    input wire logic game_rst,
    input wire logic joy_clk,
    input wire logic joy_load,
    input wire logic soft_rst,
    input wire gfx_t gfx_en
);

    // soft reset request is a one cycle strobe
    soft_rst_single: assert property (
        @(posedge clk_sys) disable iff (game_rst)
        soft_rst |=> !soft_rst
    ) else $error("soft_rst stayed high for two cycles");

    // load was high in the tick period before any low one
    load_one_tick: assert property (
        @(posedge clk_sys) disable iff (game_rst)
        ($rose(joy_clk) && !joy_load) |-> $past(joy_load)
    ) else $error("joy_load low on two consecutive ticks");

    gfx_after_reset: assert property (
        @(posedge clk_sys)
        $fell(game_rst) |-> (gfx_en == 4'hf)
    ) else $error("gfx_en not all ones after reset release");

endmodule

bind board_inputs board_properties board_properties_i (
    .clk_sys  (clk_sys),
    .game_rst (game_rst),
    .joy_clk  (joy_clk),
    .joy_load (joy_load),
    .soft_rst (soft_rst),
    .gfx_en   (gfx_en)
);

`default_nettype wire

/* tb/board_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "board_cfg.svh"

module board_tb import board_pkg::*; ();

    localparam int CLK_HALF   = 4;
    localparam int TICK_LIMIT = (1 << `JOY_DIV_BITS) + 16;
    localparam int LOAD_LIMIT = `JOY_FRAME_LEN * (1 << `JOY_DIV_BITS) + TICK_LIMIT;

    localparam joy_word_t JOY_POL  = {10{`INPUTS_ACTIVE_LOW}};
    localparam pair_t     PAIR_POL = {2{`INPUTS_ACTIVE_LOW}};

    logic        clk_sys;
    logic        game_rst;
    logic        joy_clk;
    logic        joy_load;
    logic        joy_data;
    joy_word_t   key_joy1;
    joy_word_t   key_joy2;
    pair_t       key_coin;
    pair_t       key_start;
    logic        key_service;
    logic        key_pause;
    logic        key_reset;
    gfx_t        key_gfx;
    logic        rot_control;
    joy_word_t   game_joystick1;
    joy_word_t   game_joystick2;
    pair_t       game_coin;
    pair_t       game_start;
    logic        game_service;
    logic        game_pause;
    gfx_t        gfx_en;
    logic        soft_rst;
    logic [31:0] rng_state;

    board_inputs board_inputs_i (
        .clk_sys        (clk_sys),
        .game_rst       (game_rst),
        .joy_clk        (joy_clk),
        .joy_load       (joy_load),
        .joy_data       (joy_data),
        .key_joy1       (key_joy1),
        .key_joy2       (key_joy2),
        .key_coin       (key_coin),
        .key_start      (key_start),
        .key_service    (key_service),
        .key_pause      (key_pause),
        .key_reset      (key_reset),
        .key_gfx        (key_gfx),
        .rot_control    (rot_control),
        .game_joystick1 (game_joystick1),
        .game_joystick2 (game_joystick2),
        .game_coin      (game_coin),
        .game_start     (game_start),
        .game_service   (game_service),
        .game_pause     (game_pause),
        .gfx_en         (gfx_en),
        .soft_rst       (soft_rst)
    );

    initial begin
        clk_sys = 1'b0;
        forever #CLK_HALF clk_sys = ~clk_sys;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic next_random(output logic [31:0] r);
        rng_state = xorshift32(rng_state);
        r = rng_state;
    endtask

    // adapter order is fire 2, fire 1, right, left, down, up
    function automatic joy_word_t serial_to_word(input logic [5:0] bits);
        joy_word_t w;
        w    = '0;
        w[5] = bits[0];
        w[4] = bits[1];
        w[0] = bits[2];
        w[1] = bits[3];
        w[2] = bits[4];
        w[3] = bits[5];
        return w;
    endfunction

    // vertical mounting keeps the buttons in place
    function automatic joy_word_t rotate_dirs(input joy_word_t w, input logic rot);
        joy_word_t r;
        r = w;
        if (rot) begin
            r[0] = w[2];    // right from down
            r[1] = w[3];    // left from up
            r[2] = w[1];
            r[3] = w[0];
        end
        return r;
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("error at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
            $display("TEST FAIL");
            $fatal(1);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout at %0t ns while waiting for %s", $time, what);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic wait_load_edge(input logic rising);
        int   n;
        logic prev;
        n    = 0;
        prev = joy_load;
        while (!(prev == !rising && joy_load == rising)) begin
            if (n >= LOAD_LIMIT) begin
                report_timeout("an edge of joy_load");
            end else begin
                prev = joy_load;
                @(negedge clk_sys);
                n++;
            end
        end
    endtask

    task automatic wait_joy_clk_fall();
        int   n;
        logic prev;
        n    = 0;
        prev = joy_clk;
        while (!(prev && !joy_clk)) begin
            if (n >= TICK_LIMIT) begin
                report_timeout("joy_clk to fall");
            end else begin
                prev = joy_clk;
                @(negedge clk_sys);
                n++;
            end
        end
    endtask

    // adapter model that drives pressed bits low
    task automatic send_frame(input logic [11:0] pattern);
        int k;
        wait_load_edge(1'b1);
        check_value(joy_clk, 1'b1, "joy_clk rising with load release");
        for (k = 0; k < 12; k++) begin
            wait_joy_clk_fall();
            check_value(joy_load, 1'b1, "joy_load high during frame");
            joy_data = ~pattern[k];
        end
    endtask

    task automatic expect_reset_state();
        check_value(game_joystick1, JOY_POL, "joystick 1 after reset");
        check_value(game_joystick2, JOY_POL, "joystick 2 after reset");
        check_value(game_coin, PAIR_POL, "coin after reset");
        check_value(game_start, PAIR_POL, "start after reset");
        check_value(game_service, `INPUTS_ACTIVE_LOW, "service after reset");
        check_value(game_pause, 1'b0, "pause after reset");
        check_value(gfx_en, 4'hf, "gfx_en after reset");
        check_value(soft_rst, 1'b0, "soft_rst after reset");
        check_value(joy_load, 1'b1, "joy_load after reset");
        check_value(joy_clk, 1'b0, "joy_clk after reset");
    endtask

    task automatic merge_keys_with_rotation();
        logic [31:0] r;
        joy_word_t   k1;
        joy_word_t   k2;
        int          i;
        for (i = 0; i < 4; i++) begin
            next_random(r);
            k1          = r[9:0];
            k2          = r[25:16];
            key_joy1    = k1;
            key_joy2    = k2;
            rot_control = i[1];   // two words straight then two rotated
            repeat (2) @(negedge clk_sys);
            check_value(game_joystick1, JOY_POL ^ rotate_dirs(k1, i[1]), "key joystick 1");
            check_value(game_joystick2, JOY_POL ^ rotate_dirs(k2, i[1]), "key joystick 2");
        end
        key_joy1    = '0;
        key_joy2    = '0;
        rot_control = 1'b0;
        repeat (2) @(negedge clk_sys);
        check_value(game_joystick1, JOY_POL, "joystick 1 keys released");
        check_value(game_joystick2, JOY_POL, "joystick 2 keys released");
    endtask

    task automatic drive_coin_start_service();
        logic [31:0] r;
        int          i;
        for (i = 0; i < 5; i++) begin
            next_random(r);
            key_coin    = r[1:0];
            key_start   = r[3:2];
            key_service = r[4];
            repeat (2) @(negedge clk_sys);
            check_value(game_coin, PAIR_POL ^ r[1:0], "coin");
            check_value(game_start, PAIR_POL ^ r[3:2], "start");
            check_value(game_service, `INPUTS_ACTIVE_LOW ^ r[4], "service");
        end
        key_coin    = '0;
        key_start   = '0;
        key_service = 1'b0;
        repeat (2) @(negedge clk_sys);
    endtask

    task automatic exercise_toggles();
        logic exp_pause;
        gfx_t exp_gfx;
        int   i;
        exp_pause = 1'b0;
        exp_gfx   = 4'hf;
        for (i = 0; i < 2; i++) begin
            key_pause = 1'b1;
            @(negedge clk_sys);
            check_value(game_pause, exp_pause, "pause one cycle after press");
            @(negedge clk_sys);
            exp_pause = ~exp_pause;
            check_value(game_pause, exp_pause, "pause two cycles after press");
            repeat (4) @(negedge clk_sys);
            check_value(game_pause, exp_pause, "pause while key held");
            key_pause = 1'b0;
            repeat (3) @(negedge clk_sys);
            check_value(game_pause, exp_pause, "pause after release");
        end
        for (i = 0; i < 4; i++) begin
            key_gfx[i] = 1'b1;
            repeat (2) @(negedge clk_sys);
            exp_gfx[i] = ~exp_gfx[i];
            check_value(gfx_en, exp_gfx, "gfx_en after layer key");
            key_gfx[i] = 1'b0;
            repeat (3) @(negedge clk_sys);
            check_value(gfx_en, exp_gfx, "gfx_en after layer key release");
        end
        // key held well past the pulse
        key_reset = 1'b1;
        for (i = 1; i <= 8; i++) begin
            @(negedge clk_sys);
            check_value(soft_rst, i == 2, "soft_rst while reset key held");
        end
        key_reset = 1'b0;
        repeat (3) @(negedge clk_sys);
        check_value(soft_rst, 1'b0, "soft_rst after reset key release");
    endtask

    task automatic decode_serial_frames();
        logic [31:0] r;
        logic [11:0] pat;
        int          i;
        for (i = 0; i < 3; i++) begin
            next_random(r);
            pat = r[11:0];
            send_frame(pat);
            wait_load_edge(1'b0);   // frame went out on the tick before
            check_value(game_joystick1, JOY_POL ^ serial_to_word(pat[5:0]), "serial player 1");
            check_value(game_joystick2, JOY_POL ^ serial_to_word(pat[11:6]), "serial player 2");
        end
        send_frame(12'h000);
        wait_load_edge(1'b0);
        check_value(game_joystick1, JOY_POL, "serial player 1 idle");
        check_value(game_joystick2, JOY_POL, "serial player 2 idle");
    endtask

    initial begin
        rng_state   = 32'd56;
        game_rst    = 1'b1;
        joy_data    = 1'b1;       // nothing pressed
        key_joy1    = '0;
        key_joy2    = '0;
        key_coin    = '0;
        key_start   = '0;
        key_service = 1'b0;
        key_pause   = 1'b0;
        key_reset   = 1'b0;
        key_gfx     = '0;
        rot_control = 1'b0;
        repeat (8) @(negedge clk_sys);
        game_rst = 1'b0;
        @(negedge clk_sys);

        expect_reset_state();
        merge_keys_with_rotation();
        drive_coin_start_service();
        exercise_toggles();
        decode_serial_frames();

        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire
